// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := alu_unit_tb
FILELIST  := build.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
SOURCES   := $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM) alu_testdata.hex
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJDIR)

// File: alu_decode.sv
/*
 * decode stage. Checks an OP or OP-IMM word, picks operand b and holds the
 * decoded operation in one stage register that stalls on a full queue.
 */
`timescale 1ns/1ps

module alu_decode import alu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            issue_valid,
    input  instr_u          issue_instr,
    input  logic [XLEN-1:0] issue_rs1,
    input  logic [XLEN-1:0] issue_rs2,
    input  logic [ID_W-1:0] issue_id,
    output logic            issue_ready,
    input  logic            stall,             // result queue cannot take the entry.
    output logic            dec_valid,
    output alu_op_t         dec_op,
    output logic [XLEN-1:0] dec_a,
    output logic [XLEN-1:0] dec_b,
    output logic [4:0]      dec_rd,
    output logic [ID_W-1:0] dec_id,
    output logic            dec_illegal
);

    logic            is_op;                    // register form.
    logic            is_imm;                   // immediate form.
    logic [2:0]      funct3;
    logic [6:0]      upper;                    // funct7 or imm12[11:5].
    logic            upper_ok;                 // upper bits are a legal pattern.
    logic            is_shift;
    logic            illegal_nxt;
    logic            load;                     // stage takes a new instruction.
    logic [XLEN-1:0] b_nxt;
    alu_op_t         op_nxt;

    assign is_op    = (issue_instr.r.opcode == OPC_OP);
    assign is_imm   = (issue_instr.i.opcode == OPC_OP_IMM);
    assign funct3   = issue_instr.r.funct3;   // same position in both views.
    assign upper    = is_op ? issue_instr.r.funct7 : issue_instr.i.imm12[11:5];
    assign is_shift = (funct3 == F3_SLL) || (funct3 == F3_SR);

    always_comb begin
        case (funct3)
            F3_ADD:  op_nxt = (is_op && upper[5]) ? ALU_SUB : ALU_ADD; // no subi.
            F3_SLL:  op_nxt = ALU_SLL;
            F3_SLT:  op_nxt = ALU_SLT;
            F3_SLTU: op_nxt = ALU_SLTU;
            F3_XOR:  op_nxt = ALU_XOR;
            F3_SR:   op_nxt = upper[5] ? ALU_SRA : ALU_SRL;
            F3_OR:   op_nxt = ALU_OR;
            F3_AND:  op_nxt = ALU_AND;
        endcase
    end

    // 0x20 is only allowed for sub, sra and srai.
    always_comb begin
        if (upper == 7'h00)
            upper_ok = 1'b1;
        else if (upper == F7_ALT)
            upper_ok = (funct3 == F3_SR) || (is_op && funct3 == F3_ADD);
        else
            upper_ok = 1'b0;
    end

    assign illegal_nxt = !(is_op || is_imm)                 // unknown opcode.
                       || (is_op && !upper_ok)              // bad funct7.
                       || (is_imm && is_shift && !upper_ok); // bad shamt upper bits.

    // sign-extended immediate, low 5 bits double as shamt.
    assign b_nxt = is_op ? issue_rs2
                         : {{(XLEN-12){issue_instr.i.imm12[11]}}, issue_instr.i.imm12};

    assign issue_ready = !dec_valid || !stall;  // empty or draining this cycle.
    assign load        = issue_valid && issue_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (issue_ready) begin
            dec_valid <= issue_valid;          // empties when nothing issued.
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            dec_op      <= op_nxt;
            dec_a       <= issue_rs1;
            dec_b       <= b_nxt;
            dec_rd      <= issue_instr.r.rd;
            dec_id      <= issue_id;
            dec_illegal <= illegal_nxt;
        end
    end

endmodule

// File: alu_exec.sv
/*
 * execute datapath. Adder, comparators, logic ops and the shared shifter,
 * with a result selector that zeroes illegal entries.
 */
`timescale 1ns/1ps

module alu_exec import alu_pkg::*; (
    input  alu_op_t         dec_op,
    input  logic [XLEN-1:0] dec_a,
    input  logic [XLEN-1:0] dec_b,
    input  logic            dec_illegal,
    output logic [XLEN-1:0] exec_result
);

    logic            sub;                      // adder computes a - b.
    logic [XLEN-1:0] b_in;                     // b or its inverse.
    logic [XLEN-1:0] sum;
    logic            carry;                    // adder carry out.
    logic            lt_s;                     // signed a < b.
    logic            lt_u;                     // unsigned a < b.
    logic            arith;
    logic            lshift;
    logic [XLEN-1:0] sh_right;
    logic [XLEN-1:0] sh_left;

    // compares reuse the subtraction.
    assign sub  = (dec_op == ALU_SUB) || (dec_op == ALU_SLT) || (dec_op == ALU_SLTU);
    assign b_in = sub ? ~dec_b : dec_b;

    assign {carry, sum} = {1'b0, dec_a} + {1'b0, b_in} + {{XLEN{1'b0}}, sub}; // +1 completes negate.

    assign lt_u = !carry;                      // borrow means a below b.
    assign lt_s = (dec_a[XLEN-1] != dec_b[XLEN-1]) ? dec_a[XLEN-1] // signs differ.
                                                    : sum[XLEN-1];

    assign lshift = (dec_op == ALU_SLL);
    assign arith  = (dec_op == ALU_SRA) && dec_a[XLEN-1]; // zero fill otherwise.

    barrel_shifter shifter_i (
        .shifter_input   (dec_a),
        .shift_amount    (dec_b[4:0]),         // only the low 5 bits count.
        .arith           (arith),
        .lshift          (lshift),
        .shifted_resultr (sh_right),
        .shifted_resultl (sh_left)
    );

    always_comb begin
        case (dec_op)
            ALU_ADD,
            ALU_SUB:  exec_result = sum;
            ALU_SLT:  exec_result = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: exec_result = {{(XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  exec_result = dec_a ^ dec_b;
            ALU_OR:   exec_result = dec_a | dec_b;
            ALU_AND:  exec_result = dec_a & dec_b;
            ALU_SLL:  exec_result = sh_left;
            ALU_SRL,
            ALU_SRA:  exec_result = sh_right;
            default:  exec_result = '0;        // unused encodings.
        endcase
        if (dec_illegal)
            exec_result = '0;                  // illegal entries return zero.
    end

endmodule

// File: alu_pkg.sv
/*
 * alu package. Data width, RV32I opcode and funct constants, ALU operation
 * codes and the two decoded views of an instruction word.
 */
package alu_pkg;

    localparam int XLEN = 32;                  // data path width.
    localparam int ID_W = 4;                   // transaction id width.

    // major opcodes handled by the unit.
    localparam logic [6:0] OPC_OP     = 7'b0110011; // register-register ALU ops.
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // register-immediate ALU ops.

    // funct3 encodings shared by OP and OP-IMM.
    localparam logic [2:0] F3_ADD  = 3'b000;   // add, sub.
    localparam logic [2:0] F3_SLL  = 3'b001;   // shift left logical.
    localparam logic [2:0] F3_SLT  = 3'b010;   // signed compare.
    localparam logic [2:0] F3_SLTU = 3'b011;   // unsigned compare.
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;   // srl, sra.
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_ALT  = 7'h20;    // selects sub and sra.

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_AND  = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_op_t;

    // R-type view of the instruction word.
    typedef struct packed {
        logic [6:0] funct7;                    // sub/sra select.
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fields_t;

    // I-type view of the instruction word.
    typedef struct packed {
        logic [11:0] imm12;                    // immediate or shamt with upper bits.
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    // one 32 bit word, read as R-type or I-type.
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

endpackage

// File: alu_testdata.hex
// columns: instruction, rs1, rs2, expected result, expected illegal flag.
// one vector per line, all values hex.
002081B3 00001234 00005678 000068AC 0
40208233 00000010 00000020 FFFFFFF0 0
FFB08293 00000003 DEADBEEF FFFFFFFE 0
0020C333 F0F0F0F0 FF00FF00 0FF00FF0 0
0020E3B3 12340000 00005678 12345678 0
0020F433 FFFF0000 0F0F0F0F 0F0F0000 0
0FF0C493 000000AA 00000000 00000055 0
8000E513 00000011 00000000 FFFFF811 0
7F00F593 12345678 00000000 00000670 0
0020A633 80000000 00000001 00000001 0
0020B6B3 80000000 00000001 00000000 0
0020A633 7FFFFFFF 80000000 00000000 0
0020B6B3 7FFFFFFF 80000000 00000001 0
FFF0A713 80000000 00000000 00000001 0
FFF0B793 80000000 00000000 00000001 0
00209833 80000001 00000007 00000080 0
00209833 00000003 0000001F 80000000 0
0020D8B3 80000000 00000010 00008000 0
4020D933 80000000 0000001F FFFFFFFF 0
4020D933 80000000 FFFFFFE0 80000000 0
0020D8B3 F0000000 00000021 78000000 0
01009993 8000ABCD 00000000 ABCD0000 0
01F0DA13 80000000 00000000 00000001 0
4070DA93 80000000 00000000 FF000000 0
00208237 00001234 00005678 00000000 1
022082B3 00000006 00000007 00000000 1
2030D313 80000000 00000000 00000000 1

// File: alu_unit.sv
/*
 * RV32I integer ALU unit. Decode stage, combinational execute and a result
 * queue between the issue and writeback handshakes.
 */
`timescale 1ns/1ps

module alu_unit import alu_pkg::*; #(
    parameter int RESULT_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            issue_valid,
    input  instr_u          issue_instr,
    input  logic [XLEN-1:0] issue_rs1,
    input  logic [XLEN-1:0] issue_rs2,
    input  logic [ID_W-1:0] issue_id,
    output logic            issue_ready,
    output logic            wb_valid,
    input  logic            wb_ready,
    output logic [XLEN-1:0] wb_result,
    output logic [4:0]      wb_rd,
    output logic [ID_W-1:0] wb_id,
    output logic            wb_illegal
);

    logic            stall;                    // queue full, hold the stage.
    logic            dec_valid;
    alu_op_t         dec_op;
    logic [XLEN-1:0] dec_a;
    logic [XLEN-1:0] dec_b;
    logic [4:0]      dec_rd;
    logic [ID_W-1:0] dec_id;
    logic            dec_illegal;
    logic [XLEN-1:0] exec_result;

    alu_decode decode_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .issue_id    (issue_id),
        .issue_ready (issue_ready),
        .stall       (stall),
        .dec_valid   (dec_valid),
        .dec_op      (dec_op),
        .dec_a       (dec_a),
        .dec_b       (dec_b),
        .dec_rd      (dec_rd),
        .dec_id      (dec_id),
        .dec_illegal (dec_illegal)
    );

    alu_exec exec_i (
        .dec_op      (dec_op),
        .dec_a       (dec_a),
        .dec_b       (dec_b),
        .dec_illegal (dec_illegal),
        .exec_result (exec_result)
    );

    result_fifo #(
        .DEPTH (RESULT_DEPTH)
    ) fifo_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (dec_valid),               // stage content goes in when room.
        .wr_result  (exec_result),
        .wr_rd      (dec_rd),
        .wr_id      (dec_id),
        .wr_illegal (dec_illegal),
        .full       (stall),
        .wb_valid   (wb_valid),
        .wb_ready   (wb_ready),
        .wb_result  (wb_result),
        .wb_rd      (wb_rd),
        .wb_id      (wb_id),
        .wb_illegal (wb_illegal)
    );

endmodule

// File: alu_unit_chk.sv
/*
 * handshake checker for the ALU unit, bound to the top level. Watches the
 * reset state and writeback stability under back-pressure.
 */
`timescale 1ns/1ps

module alu_unit_chk import alu_pkg::*; (
    input logic            clk,
    input logic            rst_n,
    input logic            issue_ready,
    input logic            wb_valid,
    input logic            wb_ready,
    input logic [XLEN-1:0] wb_result,
    input logic [4:0]      wb_rd,
    input logic [ID_W-1:0] wb_id,
    input logic            wb_illegal
);

    int failures = 0;                          // read by the testbench at the end.

    // stage and queue stay empty while reset is applied.
    reset_state: assert property (@(posedge clk) !rst_n |-> !wb_valid && issue_ready)
        else begin
            $error("writeback valid or issue stalled during reset");
            failures++;
        end

    // a stalled writeback keeps its whole payload.
    wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb_result) && $stable(wb_rd)
                                  && $stable(wb_id) && $stable(wb_illegal))
        else begin
            $error("writeback payload changed while stalled");
            failures++;
        end

endmodule

// File: alu_unit_tb.sv
/*
 * testbench for the ALU unit. Replays the hex vectors through the issue port
 * with random gaps and writeback back-pressure, and checks every result.
 */
`timescale 1ns/1ps

module alu_unit_tb import alu_pkg::*; ();

    localparam int          NVEC   = 27;           // vectors in the data file.
    localparam int          PERIOD = 10;           // ns.
    localparam logic [31:0] SEED   = 32'h7f7704bb;

    logic            clk;
    logic            rst_n;
    logic            issue_valid;
    instr_u          issue_instr;
    logic [XLEN-1:0] issue_rs1;
    logic [XLEN-1:0] issue_rs2;
    logic [ID_W-1:0] issue_id;
    logic            issue_ready;
    logic            wb_valid;
    logic            wb_ready;
    logic [XLEN-1:0] wb_result;
    logic [4:0]      wb_rd;
    logic [ID_W-1:0] wb_id;
    logic            wb_illegal;

    logic [31:0] tdata [NVEC*5];                   // instr, rs1, rs2, result, illegal.
    logic [31:0] issue_lfsr;                       // gap pattern state.
    logic [31:0] ready_lfsr;                       // wb_ready pattern state.
    int          checks;
    int          errors;
    logic        stalled;                          // issue_ready seen low under valid.

    alu_unit #(.RESULT_DEPTH(4)) dut_i (.*);

    bind alu_unit alu_unit_chk chk_i (
        .clk (clk), .rst_n (rst_n), .issue_ready (issue_ready),
        .wb_valid (wb_valid), .wb_ready (wb_ready), .wb_result (wb_result),
        .wb_rd (wb_rd), .wb_id (wb_id), .wb_illegal (wb_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    // galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit.
    function automatic logic draw_bit(inout logic [31:0] state);
        logic b;
        b     = state[0];
        state = state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
        return b;
    endfunction

    task automatic drive_vector(input int idx);
        issue_valid = 1'b1;
        issue_instr = tdata[idx*5];
        issue_rs1   = tdata[idx*5+1];
        issue_rs2   = tdata[idx*5+2];
        issue_id    = idx[ID_W-1:0];               // id is the index mod 16.
    endtask

    task automatic check_beat(input int idx);
        logic [31:0] exp_instr;
        logic [31:0] exp_result;
        logic        exp_illegal;
        int          errors_before;
        exp_instr     = tdata[idx*5];
        exp_result    = tdata[idx*5+3];
        exp_illegal   = tdata[idx*5+4][0];
        errors_before = errors;
        checks++;
        assert (wb_result === exp_result) else begin
            $display("[FAIL] vector %0d wb_result %h expected %h", idx, wb_result, exp_result);
            errors++;
        end
        assert (wb_illegal === exp_illegal) else begin
            $display("[FAIL] vector %0d wb_illegal %h expected %h", idx, wb_illegal, exp_illegal);
            errors++;
        end
        assert (wb_rd === exp_instr[11:7]) else begin   // rd field of the word.
            $display("[FAIL] vector %0d wb_rd %h expected %h", idx, wb_rd, exp_instr[11:7]);
            errors++;
        end
        assert (wb_id === idx[ID_W-1:0]) else begin
            $display("[FAIL] vector %0d wb_id %h expected %h", idx, wb_id, idx[ID_W-1:0]);
            errors++;
        end
        $display("vector %0d id %h rd %0d %s", idx, wb_id, wb_rd,
                 (errors == errors_before) ? "ok" : "mismatch");
    endtask

    // issue side, random gaps, signals held until accepted.
    task automatic send_all();
        int   idx;
        logic pending;
        logic b0;
        logic b1;
        idx     = 0;
        pending = 1'b0;
        while (idx < NVEC) begin
            @(negedge clk);
            if (!pending) begin
                b0 = draw_bit(issue_lfsr);
                b1 = draw_bit(issue_lfsr);
                if (b0 || b1) begin
                    drive_vector(idx);
                    pending = 1'b1;
                end else begin
                    issue_valid = 1'b0;            // gap cycle.
                end
            end
            @(posedge clk);                        // values settled since the negedge.
            if (pending && issue_ready) begin
                pending = 1'b0;
                idx++;
            end else if (pending) begin
                stalled = 1'b1;
            end
        end
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    // writeback side, wb_ready mostly low so the queue fills.
    task automatic collect_all();
        int   got;
        logic b0;
        logic b1;
        got = 0;
        while (got < NVEC) begin
            @(negedge clk);
            b0 = draw_bit(ready_lfsr);
            b1 = draw_bit(ready_lfsr);
            wb_ready = b0 && b1;
            if (wb_valid && wb_ready) begin        // taken on the next edge.
                check_beat(got);
                got++;
            end
        end
        @(negedge clk);
        wb_ready = 1'b1;
    endtask

    initial begin
        repeat (NVEC*20 + 100) @(posedge clk);
        $display("run timed out before all results came back");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int   edges;
        logic accepted;
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue_instr = '0;
        issue_rs1   = '0;
        issue_rs2   = '0;
        issue_id    = '0;
        wb_ready    = 1'b0;
        issue_lfsr  = SEED;
        ready_lfsr  = SEED;
        checks      = 0;
        errors      = 0;
        stalled     = 1'b0;
        $readmemh("alu_testdata.hex", tdata);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // latency on one isolated issue, queue empty and wb_ready high.
        @(negedge clk);
        wb_ready = 1'b1;
        drive_vector(0);
        @(posedge clk);
        accepted = issue_ready;                    // accepting edge.
        @(negedge clk);
        issue_valid = 1'b0;
        edges       = 1;
        while (!wb_valid && edges < 8) begin
            @(negedge clk);
            edges++;
        end
        checks++;
        assert (accepted && edges == 2) else begin
            $display("wb_valid came %0d edges after the issue instead of 2", edges);
            errors++;
        end
        check_beat(0);
        $display("latency test: wb_valid after %0d edges", edges);
        @(negedge clk);

        fork
            send_all();
            collect_all();
        join

        repeat (4) @(negedge clk);
        checks += 2;
        assert (!wb_valid) else begin
            $display("extra writeback after the last vector");
            errors++;
        end
        assert (stalled) else begin
            $display("issue_ready never dropped under back-pressure");
            errors++;
        end
        $display("back-pressure test: %0d vectors returned in order", NVEC);
        errors += dut_i.chk_i.failures;            // bound assertion failures.
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: barrel_shifter.sv
/*
 * barrel shifter. One right shift tree serves both directions by reversing
 * the bits of the input and the output for left shifts.
 */
`timescale 1ns/1ps

module barrel_shifter import alu_pkg::*; (
    input  logic [XLEN-1:0] shifter_input,
    input  logic [4:0]      shift_amount,
    input  logic            arith,             // fill bit for vacated positions.
    input  logic            lshift,            // selects the reversed input.
    output logic [XLEN-1:0] shifted_resultr,
    output logic [XLEN-1:0] shifted_resultl
);

    logic [XLEN-1:0] reversed_input;           // input with bit order flipped.
    logic [XLEN-1:0] stage1;                   // after the shift by 1.
    logic [XLEN-1:0] stage2;                   // after the shift by 2, 4 or 6.
    logic [XLEN-1:0] stage3;                   // after the shift by 8, 16 or 24.

    always_comb begin
        foreach (shifter_input[i])
            reversed_input[i] = shifter_input[XLEN-1-i]; // msb becomes lsb.
    end

    always_comb begin
        case ({lshift, shift_amount[0]})
            2'b00: stage1 = shifter_input;
            2'b01: stage1 = {arith, shifter_input[XLEN-1:1]};
            2'b10: stage1 = reversed_input;
            2'b11: stage1 = {arith, reversed_input[XLEN-1:1]};
        endcase
    end

    always_comb begin
        case (shift_amount[2:1])
            2'd0: stage2 = stage1;
            2'd1: stage2 = {{2{arith}}, stage1[XLEN-1:2]};
            2'd2: stage2 = {{4{arith}}, stage1[XLEN-1:4]};
            2'd3: stage2 = {{6{arith}}, stage1[XLEN-1:6]};
        endcase
    end

    always_comb begin
        case (shift_amount[4:3])
            2'd0: stage3 = stage2;
            2'd1: stage3 = {{8{arith}}, stage2[XLEN-1:8]};
            2'd2: stage3 = {{16{arith}}, stage2[XLEN-1:16]};
            2'd3: stage3 = {{24{arith}}, stage2[XLEN-1:24]};
        endcase
    end

    assign shifted_resultr = stage3;           // right shift result.

    always_comb begin
        foreach (stage3[i])
            shifted_resultl[i] = stage3[XLEN-1-i]; // flip back for left shift.
    end

endmodule

// File: build.f
alu_pkg.sv
barrel_shifter.sv
alu_decode.sv
alu_exec.sv
result_fifo.sv
alu_unit.sv
alu_unit_chk.sv
alu_unit_tb.sv

// File: result_fifo.sv
/*
 * result queue. Circular buffer of completed results in issue order,
 * drained by the writeback valid/ready handshake.
 */
`timescale 1ns/1ps

module result_fifo import alu_pkg::*; #(
    parameter int DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            wr_en,
    input  logic [XLEN-1:0] wr_result,
    input  logic [4:0]      wr_rd,
    input  logic [ID_W-1:0] wr_id,
    input  logic            wr_illegal,
    output logic            full,              // no room this cycle.
    output logic            wb_valid,
    input  logic            wb_ready,
    output logic [XLEN-1:0] wb_result,
    output logic [4:0]      wb_rd,
    output logic [ID_W-1:0] wb_id,
    output logic            wb_illegal
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [XLEN-1:0]  mem_result [DEPTH];
    logic [4:0]       mem_rd     [DEPTH];
    logic [ID_W-1:0]  mem_id     [DEPTH];
    logic             mem_ill    [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;                   // entries held.
    logic             wr_fire;
    logic             rd_fire;

    assign wb_valid = (count != '0);
    assign rd_fire  = wb_valid && wb_ready;
    assign full     = (count == CNT_W'(DEPTH)) && !rd_fire; // a read frees a slot.
    assign wr_fire  = wr_en && !full;

    assign wb_result  = mem_result[rd_ptr];    // head of the queue.
    assign wb_rd      = mem_rd[rd_ptr];
    assign wb_id      = mem_id[rd_ptr];
    assign wb_illegal = mem_ill[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1; // wrap.
            if (rd_fire)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            if (wr_fire && !rd_fire)
                count <= count + 1'b1;
            else if (rd_fire && !wr_fire)
                count <= count - 1'b1;         // unchanged when both fire.
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem_result[wr_ptr] <= wr_result;
            mem_rd[wr_ptr]     <= wr_rd;
            mem_id[wr_ptr]     <= wr_id;
            mem_ill[wr_ptr]    <= wr_illegal;
        end
    end

endmodule
